// File: tsn_mgmt_pkg.sv
`default_nettype none

package tsn_mgmt_pkg;

    typedef logic [4:0]  phy_addr_t;  // mdio phy address
    typedef logic [4:0]  reg_addr_t;  // mdio and pcs register address
    typedef logic [15:0] reg_data_t;  // register value
    typedef logic [1:0]  port_id_t;   // sgmii port number

    typedef struct packed {
        logic      wr;    // write strobe, level
        reg_addr_t addr;
        reg_data_t data;
    } pcs_req_t;          // one sequencer request

    typedef struct packed {
        port_id_t  port;  // owner of the write
        logic      wr;
        reg_addr_t addr;
        reg_data_t data;
    } pcs_bus_t;          // shared pcs bus request

    typedef struct packed {
        reg_addr_t addr;
        reg_data_t data;
    } init_entry_t;       // one init table entry

    typedef enum logic [1:0] {RST_HOLD, RST_WAKE, RST_DONE} rst_state_t;
    typedef enum logic [1:0] {MD_IDLE, MD_SHIFT, MD_GAP, MD_DONE} mdio_state_t;
    typedef enum logic [1:0] {SEQ_ISSUE, SEQ_WAIT, SEQ_DONE} seq_state_t;

    localparam phy_addr_t PHY_ADDR = 5'd1;  // external phy strap address

    localparam int PHY_INIT_LEN = 3;
    localparam init_entry_t PHY_INIT_TABLE [PHY_INIT_LEN] = '{
        '{5'd0,  16'h1140},  // copper control, an on, 1000 full
        '{5'd27, 16'h9084},  // sgmii to copper mode
        '{5'd0,  16'h9140}   // soft reset to apply mode
    };

    localparam int PCS_INIT_LEN = 3;
    localparam init_entry_t PCS_INIT_TABLE [PCS_INIT_LEN] = '{
        '{5'h12, 16'h0d40},  // link timer low word
        '{5'h13, 16'h0003},  // link timer high word, 1.6 ms
        '{5'h14, 16'h0003}   // if_mode sgmii with sgmii an
    };

    localparam int MDIO_FRAME_BITS = 64;  // preamble 32 plus clause 22 frame

endpackage

`default_nettype wire

// File: phy_reset_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module phy_reset_ctrl
    import tsn_mgmt_pkg::*;
#(
    parameter int PHY_RST_CYCLES  = 20,
    parameter int PHY_WAKE_CYCLES = 10
) (
    input  logic FPGA_SYS_CLK,
    input  logic FPGA_SYS_RST_N,
    output logic o_phy_rst_n,   // to external phy
    output logic o_mdio_start   // stays high once set
);

    localparam int MAX_CYC = (PHY_RST_CYCLES > PHY_WAKE_CYCLES) ? PHY_RST_CYCLES : PHY_WAKE_CYCLES;
    localparam int CNT_W   = $clog2(MAX_CYC + 1);

    rst_state_t       state;
    logic [CNT_W-1:0] cnt;   // shared by hold and wake phases

    always_ff @(posedge FPGA_SYS_CLK) begin
        if (!FPGA_SYS_RST_N) begin
            state        <= RST_HOLD;
            cnt          <= '0;
            o_phy_rst_n  <= 1'b0;  // phy held in reset
            o_mdio_start <= 1'b0;
        end else begin
            case (state)
                RST_HOLD: begin
                    if (cnt == CNT_W'(PHY_RST_CYCLES - 1)) begin
                        o_phy_rst_n <= 1'b1;  // release phy
                        cnt         <= '0;
                        state       <= RST_WAKE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RST_WAKE: begin
                    if (cnt == CNT_W'(PHY_WAKE_CYCLES - 1)) begin
                        o_mdio_start <= 1'b1;  // phy awake, mdio may start
                        state        <= RST_DONE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                RST_DONE: state <= RST_DONE;  // parked until next reset
                default:  state <= RST_HOLD;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: mdio_init_master.sv
`default_nettype none
`timescale 1ns/100ps

module mdio_init_master
    import tsn_mgmt_pkg::*;
#(
    parameter int MDC_HALF = 4
) (
    input  logic FPGA_SYS_CLK,
    input  logic FPGA_SYS_RST_N,
    input  logic i_mdio_start,   // level from reset ctrl
    output logic o_phy_mdc,
    output logic o_phy_mdio,
    output logic o_phy_mdio_oe,  // high only inside a frame
    output logic o_init_done
);

    localparam int DIV_W = (MDC_HALF > 1) ? $clog2(MDC_HALF) : 1;
    localparam int BIT_W = $clog2(MDIO_FRAME_BITS);
    localparam int IDX_W = (PHY_INIT_LEN > 1) ? $clog2(PHY_INIT_LEN) : 1;

    mdio_state_t                state;
    logic [DIV_W-1:0]           div_cnt;    // mdc half period counter
    logic                       mdc_en;
    logic                       half_tick;
    logic                       mdc_fall;   // mdc about to go low
    logic [IDX_W-1:0]           entry_idx;  // current phy table entry
    logic [BIT_W-1:0]           bit_cnt;
    logic [MDIO_FRAME_BITS-1:0] frame;
    logic [MDIO_FRAME_BITS-1:0] shift_reg;
    init_entry_t                cur_entry;

    assign mdc_en    = i_mdio_start && (state != MD_DONE);  // mdc parks low when done
    assign half_tick = mdc_en && (div_cnt == DIV_W'(MDC_HALF - 1));
    assign mdc_fall  = half_tick && o_phy_mdc;

    assign cur_entry = PHY_INIT_TABLE[entry_idx];

    // clause 22 write frame, msb goes out first
    assign frame = {
        {32{1'b1}},      // preamble
        2'b01,           // start
        2'b01,           // write op
        PHY_ADDR,
        cur_entry.addr,
        2'b10,           // turnaround
        cur_entry.data
    };

    assign o_init_done = (state == MD_DONE);

    always_ff @(posedge FPGA_SYS_CLK) begin
        if (!FPGA_SYS_RST_N) begin
            div_cnt   <= '0;
            o_phy_mdc <= 1'b0;
        end else if (mdc_en) begin
            if (half_tick) begin
                div_cnt   <= '0;
                o_phy_mdc <= ~o_phy_mdc;  // toggle every half period
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge FPGA_SYS_CLK) begin
        if (mdc_fall && state == MD_IDLE) begin
            shift_reg <= {frame[MDIO_FRAME_BITS-2:0], 1'b1};  // first bit goes out directly
        end else if (mdc_fall && state == MD_SHIFT) begin
            shift_reg <= {shift_reg[MDIO_FRAME_BITS-2:0], 1'b1};
        end
    end

    always_ff @(posedge FPGA_SYS_CLK) begin
        if (!FPGA_SYS_RST_N) begin
            state         <= MD_IDLE;
            entry_idx     <= '0;
            bit_cnt       <= '0;
            o_phy_mdio    <= 1'b1;  // idle line high
            o_phy_mdio_oe <= 1'b0;
        end else if (mdc_fall) begin  // all data moves on mdc fall
            case (state)
                MD_IDLE: begin
                    o_phy_mdio    <= frame[MDIO_FRAME_BITS-1];
                    o_phy_mdio_oe <= 1'b1;
                    bit_cnt       <= '0;
                    state         <= MD_SHIFT;
                end
                MD_SHIFT: begin
                    if (bit_cnt == BIT_W'(MDIO_FRAME_BITS - 1)) begin
                        o_phy_mdio    <= 1'b1;  // frame over, release line
                        o_phy_mdio_oe <= 1'b0;
                        state         <= MD_GAP;
                    end else begin
                        o_phy_mdio <= shift_reg[MDIO_FRAME_BITS-1];
                        bit_cnt    <= bit_cnt + 1'b1;
                    end
                end
                MD_GAP: begin  // one idle mdc period at least
                    if (entry_idx == IDX_W'(PHY_INIT_LEN - 1)) begin
                        state <= MD_DONE;
                    end else begin
                        entry_idx <= entry_idx + 1'b1;
                        state     <= MD_IDLE;
                    end
                end
                MD_DONE: state <= MD_DONE;
                default: state <= MD_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: pcs_config_seq.sv
`default_nettype none
`timescale 1ns/100ps

module pcs_config_seq
    import tsn_mgmt_pkg::*;
(
    input  logic     FPGA_SYS_CLK,
    input  logic     FPGA_SYS_RST_N,
    output pcs_req_t o_req,   // write request to arbiter
    input  logic     i_busy,  // waitrequest from arbiter
    output logic     o_done   // table fully written, drives led
);

    localparam int IDX_W = (PCS_INIT_LEN > 1) ? $clog2(PCS_INIT_LEN) : 1;

    seq_state_t       state;
    logic [IDX_W-1:0] idx;       // next table entry
    logic             accepted;
    init_entry_t      cur_entry;

    assign cur_entry  = PCS_INIT_TABLE[idx];
    assign o_req.wr   = (state == SEQ_ISSUE);  // held until accepted
    assign o_req.addr = cur_entry.addr;
    assign o_req.data = cur_entry.data;
    assign accepted   = o_req.wr && !i_busy;
    assign o_done     = (state == SEQ_DONE);

    always_ff @(posedge FPGA_SYS_CLK) begin
        if (!FPGA_SYS_RST_N) begin
            state <= SEQ_ISSUE;  // first write right out of reset
            idx   <= '0;
        end else begin
            case (state)
                SEQ_ISSUE: begin
                    if (accepted) begin
                        if (idx == IDX_W'(PCS_INIT_LEN - 1)) begin
                            state <= SEQ_DONE;  // last entry taken
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= SEQ_WAIT;
                        end
                    end
                end
                SEQ_WAIT:  state <= SEQ_ISSUE;  // one cycle gap, wr low
                SEQ_DONE:  state <= SEQ_DONE;
                default:   state <= SEQ_ISSUE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: pcs_reg_arbiter.sv
`default_nettype none
`timescale 1ns/100ps

module pcs_reg_arbiter
    import tsn_mgmt_pkg::*;
#(
    parameter int NUM_PORTS = 4
) (
    input  logic                 FPGA_SYS_CLK,
    input  logic                 FPGA_SYS_RST_N,
    input  pcs_req_t             i_req [NUM_PORTS],  // one per sequencer
    output logic [NUM_PORTS-1:0] o_busy,
    output pcs_bus_t             o_bus,              // shared pcs register bus
    input  logic                 i_bus_busy          // bus waitrequest
);

    port_id_t last;      // previous winner
    port_id_t gnt;       // current grant
    logic     gnt_vld;
    port_id_t pick;      // next winner, combinational
    logic     pick_vld;
    logic     accept;

    // round robin search starting after the last winner
    always_comb begin
        port_id_t cand;
        pick     = last;
        pick_vld = 1'b0;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            cand = port_id_t'((int'(last) + i) % NUM_PORTS);
            if (!pick_vld && i_req[cand].wr) begin
                pick     = cand;
                pick_vld = 1'b1;
            end
        end
    end

    assign o_bus.port = gnt;
    assign o_bus.wr   = gnt_vld && i_req[gnt].wr;  // only granted request leaves
    assign o_bus.addr = i_req[gnt].addr;
    assign o_bus.data = i_req[gnt].data;
    assign accept     = o_bus.wr && !i_bus_busy;

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            o_busy[p] = !(accept && (gnt == port_id_t'(p)));  // others see busy
        end
    end

    always_ff @(posedge FPGA_SYS_CLK) begin
        if (!FPGA_SYS_RST_N) begin
            gnt_vld <= 1'b0;
            gnt     <= '0;
            last    <= port_id_t'(NUM_PORTS - 1);  // so port 0 wins first
        end else if (gnt_vld) begin
            if (accept) begin
                gnt_vld <= 1'b0;  // write done, rearbitrate next cycle
                last    <= gnt;
            end
        end else if (pick_vld) begin
            gnt_vld <= 1'b1;      // grant forwarded next cycle
            gnt     <= pick;
        end
    end

endmodule

`default_nettype wire

// File: tsn_mgmt_top.sv
`default_nettype none
`timescale 1ns/100ps

module tsn_mgmt_top
    import tsn_mgmt_pkg::*;
#(
    parameter int MDC_HALF        = 4,
    parameter int PHY_RST_CYCLES  = 20,
    parameter int PHY_WAKE_CYCLES = 10,
    parameter int NUM_PORTS       = 4
) (
    input  logic                 FPGA_SYS_CLK,
    input  logic                 FPGA_SYS_RST_N,
    // external phy
    output logic                 o_phy_rst_n,
    output logic                 o_phy_mdc,
    output logic                 o_phy_mdio,
    output logic                 o_phy_mdio_oe,  // no reads, so no inout
    // pcs register bus
    output pcs_bus_t             o_pcs_bus,
    input  logic                 i_pcs_busy,     // waitrequest
    output logic [NUM_PORTS-1:0] o_led           // per port pcs configured
);

    logic                 mdio_start;             // reset ctrl to mdio master
    pcs_req_t             port_req [NUM_PORTS];   // sequencer requests
    logic [NUM_PORTS-1:0] port_busy;              // per port waitrequest

    phy_reset_ctrl #(
        .PHY_RST_CYCLES  (PHY_RST_CYCLES),
        .PHY_WAKE_CYCLES (PHY_WAKE_CYCLES)
    ) u_phy_reset_ctrl (
        .FPGA_SYS_CLK   (FPGA_SYS_CLK),
        .FPGA_SYS_RST_N (FPGA_SYS_RST_N),
        .o_phy_rst_n    (o_phy_rst_n),
        .o_mdio_start   (mdio_start)
    );

    mdio_init_master #(
        .MDC_HALF (MDC_HALF)
    ) u_mdio_init_master (
        .FPGA_SYS_CLK   (FPGA_SYS_CLK),
        .FPGA_SYS_RST_N (FPGA_SYS_RST_N),
        .i_mdio_start   (mdio_start),
        .o_phy_mdc      (o_phy_mdc),
        .o_phy_mdio     (o_phy_mdio),
        .o_phy_mdio_oe  (o_phy_mdio_oe),
        .o_init_done    ()                  // phy init status unused here
    );

    for (genvar g = 0; g < NUM_PORTS; g++) begin : g_port
        pcs_config_seq u_pcs_config_seq (
            .FPGA_SYS_CLK   (FPGA_SYS_CLK),
            .FPGA_SYS_RST_N (FPGA_SYS_RST_N),
            .o_req          (port_req[g]),
            .i_busy         (port_busy[g]),
            .o_done         (o_led[g])      // led lit once pcs configured
        );
    end

    pcs_reg_arbiter #(
        .NUM_PORTS (NUM_PORTS)
    ) u_pcs_reg_arbiter (
        .FPGA_SYS_CLK   (FPGA_SYS_CLK),
        .FPGA_SYS_RST_N (FPGA_SYS_RST_N),
        .i_req          (port_req),
        .o_busy         (port_busy),
        .o_bus          (o_pcs_bus),
        .i_bus_busy     (i_pcs_busy)
    );

endmodule

`default_nettype wire

// File: tb_tsn_mgmt_assertions.sv
`default_nettype none
`timescale 1ns/100ps

module tb_tsn_mgmt_assertions
    import tsn_mgmt_pkg::*;
(
    input logic       FPGA_SYS_CLK,
    input logic       FPGA_SYS_RST_N,
    input logic       o_phy_rst_n,
    input logic       o_phy_mdio_oe,
    input pcs_bus_t   o_pcs_bus,
    input logic       i_pcs_busy,
    input logic [3:0] o_led
);

    // request frozen while the bus holds it off
    a_bus_stable: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
        (o_pcs_bus.wr && i_pcs_busy) |=> (o_pcs_bus == $past(o_pcs_bus)))
        else $error("pcs bus request changed while waitrequest was high");

    // no mdio drive into a phy held in reset
    a_mdio_off_in_reset: assert property (@(posedge FPGA_SYS_CLK)
        !o_phy_rst_n |-> !o_phy_mdio_oe)
        else $error("mdio output enabled while phy reset is low");

    // configured flags are sticky
    a_led_sticky: assert property (@(posedge FPGA_SYS_CLK) disable iff (!FPGA_SYS_RST_N)
        (($past(o_led) & ~o_led) == 4'b0000))
        else $error("led bit fell after it had risen");

endmodule

bind tsn_mgmt_top tb_tsn_mgmt_assertions u_tb_tsn_mgmt_assertions (.*);

`default_nettype wire

// File: tb_tsn_mgmt.sv
`default_nettype none
`timescale 1ns/100ps

module tb_tsn_mgmt
    import tsn_mgmt_pkg::*;
();

    localparam int MDC_HALF        = 4;
    localparam int PHY_RST_CYCLES  = 20;
    localparam int PHY_WAKE_CYCLES = 10;
    localparam int NUM_PORTS       = 4;
    localparam int RST_CYCLES      = 5;   // board reset length
    localparam int SETTLE_CYCLES   = 8 * MDC_HALF;  // quiet tail after last activity
    localparam int TIMEOUT_CYCLES  = 2 * (RST_CYCLES + PHY_RST_CYCLES + PHY_WAKE_CYCLES
                                   + PHY_INIT_LEN * (MDIO_FRAME_BITS + 2) * 2 * MDC_HALF
                                   + NUM_PORTS * PCS_INIT_LEN * 5);

    logic                 sys_clk;
    logic                 sys_rst_n;
    logic                 o_phy_rst_n;
    logic                 o_phy_mdc;
    logic                 o_phy_mdio;
    logic                 o_phy_mdio_oe;
    pcs_bus_t             o_pcs_bus;
    logic                 i_pcs_busy;
    logic [NUM_PORTS-1:0] o_led;

    logic [31:0] lfsr = 32'h5b7d10db;  // fixed seed
    int          errors = 0;
    int          pcs_writes = 0;
    int          frames_seen = 0;
    int          cyc = 0;              // cycles since reset release
    int          exp_idx [NUM_PORTS];  // next table entry per port
    int          last_port = NUM_PORTS - 1;
    int          bit_cnt = 0;          // mdio bits of current frame
    logic [63:0] frame_bits;
    logic        mdc_prev = 1'b0;

    tsn_mgmt_top #(
        .MDC_HALF        (MDC_HALF),
        .PHY_RST_CYCLES  (PHY_RST_CYCLES),
        .PHY_WAKE_CYCLES (PHY_WAKE_CYCLES),
        .NUM_PORTS       (NUM_PORTS)
    ) u_tsn_mgmt_top (
        .FPGA_SYS_CLK   (sys_clk),
        .FPGA_SYS_RST_N (sys_rst_n),
        .o_phy_rst_n    (o_phy_rst_n),
        .o_phy_mdc      (o_phy_mdc),
        .o_phy_mdio     (o_phy_mdio),
        .o_phy_mdio_oe  (o_phy_mdio_oe),
        .o_pcs_bus      (o_pcs_bus),
        .i_pcs_busy     (i_pcs_busy),
        .o_led          (o_led)
    );

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;  // taps 32 22 2 1
        end
        return s >> 1;
    endfunction

    task automatic take_bit(output logic b);
        lfsr = lfsr_step(lfsr);
        b    = lfsr[0];
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] got);
        errors = errors + 1;
        $display("ERROR t=%0t %s expected %0h got %0h", $time, name, exp, got);
    endtask

    task automatic report_failure(input string what);
        errors = errors + 1;
        $display("FAILURE t=%0t %s", $time, what);
    endtask

    function automatic logic [NUM_PORTS-1:0] done_mask();
        logic [NUM_PORTS-1:0] m;
        for (int p = 0; p < NUM_PORTS; p++) begin
            m[p] = (exp_idx[p] >= PCS_INIT_LEN);  // port has written its whole table
        end
        return m;
    endfunction

    // round robin after the previous winner among ports with entries left
    function automatic int next_port(input int after);
        int c;
        int found;
        found = -1;
        for (int i = 1; i <= NUM_PORTS; i++) begin
            c = (after + i) % NUM_PORTS;
            if (found < 0 && exp_idx[c] < PCS_INIT_LEN) begin
                found = c;
            end
        end
        return found;
    endfunction

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;  // 40 ns period
    end

    // busy runs of 0 to 3 cycles with one free cycle after each
    initial begin
        logic [1:0] run_bits;
        int         busy_left;
        busy_left  = 0;
        i_pcs_busy = 1'b0;
        forever begin
            @(posedge sys_clk);
            #2;
            if (busy_left == 0) begin
                i_pcs_busy = 1'b0;
                take_bit(run_bits[1]);
                take_bit(run_bits[0]);
                busy_left = run_bits;
            end else begin
                i_pcs_busy = 1'b1;
                busy_left  = busy_left - 1;
            end
        end
    end

    always @(negedge sys_clk) begin
        int          p;
        int          exp_port;
        logic [63:0] exp_frame;
        if (sys_rst_n) begin
            if (o_phy_rst_n != (cyc >= PHY_RST_CYCLES)) begin
                report_mismatch("o_phy_rst_n", cyc >= PHY_RST_CYCLES, o_phy_rst_n);
            end
            if (o_phy_mdio_oe && cyc < PHY_RST_CYCLES + PHY_WAKE_CYCLES) begin
                report_failure("MDIO output enabled before the PHY wake-up wait ended");
            end
            if (o_phy_mdc && !mdc_prev) begin  // mdc rising edge samples stable data
                if (o_phy_mdio_oe) begin
                    frame_bits = {frame_bits[62:0], o_phy_mdio};
                    bit_cnt    = bit_cnt + 1;
                    if (bit_cnt == MDIO_FRAME_BITS) begin
                        if (frames_seen >= PHY_INIT_LEN) begin
                            report_failure("MDIO frame seen after the whole PHY table");
                        end else begin
                            exp_frame = {32'hffff_ffff, 2'b01, 2'b01, PHY_ADDR,
                                         PHY_INIT_TABLE[frames_seen].addr, 2'b10,
                                         PHY_INIT_TABLE[frames_seen].data};
                            if (frame_bits != exp_frame) begin
                                report_mismatch("mdio_frame", exp_frame, frame_bits);
                            end
                        end
                        frames_seen = frames_seen + 1;
                        bit_cnt     = 0;
                    end
                end else if (bit_cnt != 0) begin
                    report_failure("MDIO output enable dropped in the middle of a frame");
                    bit_cnt = 0;
                end
            end
            if (o_led != done_mask()) begin  // led lags last accept by one cycle
                report_mismatch("o_led", done_mask(), o_led);
            end
            if (o_pcs_bus.wr && (&done_mask())) begin
                report_failure("PCS write request after every port finished its table");
            end else if (o_pcs_bus.wr && !i_pcs_busy) begin  // accepted this cycle
                p        = int'(o_pcs_bus.port);
                exp_port = next_port(last_port);
                if (p != exp_port) begin
                    report_mismatch("o_pcs_bus.port", exp_port, o_pcs_bus.port);
                end
                if (exp_idx[p] < PCS_INIT_LEN) begin
                    if (o_pcs_bus.addr != PCS_INIT_TABLE[exp_idx[p]].addr) begin
                        report_mismatch("o_pcs_bus.addr", PCS_INIT_TABLE[exp_idx[p]].addr,
                                        o_pcs_bus.addr);
                    end
                    if (o_pcs_bus.data != PCS_INIT_TABLE[exp_idx[p]].data) begin
                        report_mismatch("o_pcs_bus.data", PCS_INIT_TABLE[exp_idx[p]].data,
                                        o_pcs_bus.data);
                    end
                    exp_idx[p] = exp_idx[p] + 1;
                end else begin
                    report_failure("PCS write from a port that had no entries left");
                end
                last_port  = p;
                pcs_writes = pcs_writes + 1;
            end
        end
        mdc_prev = o_phy_mdc;
    end

    initial begin
        sys_rst_n = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            exp_idx[p] = 0;
        end
        repeat (RST_CYCLES - 1) @(posedge sys_clk);
        @(negedge sys_clk);  // idle levels while in reset
        if (o_phy_rst_n != 1'b0) report_mismatch("o_phy_rst_n", 0, o_phy_rst_n);
        if (o_phy_mdc != 1'b0) report_mismatch("o_phy_mdc", 0, o_phy_mdc);
        if (o_phy_mdio_oe != 1'b0) report_mismatch("o_phy_mdio_oe", 0, o_phy_mdio_oe);
        if (o_phy_mdio != 1'b1) report_mismatch("o_phy_mdio", 1, o_phy_mdio);
        if (o_pcs_bus.wr != 1'b0) report_mismatch("o_pcs_bus.wr", 0, o_pcs_bus.wr);
        if (o_led != '0) report_mismatch("o_led", 0, o_led);
        @(posedge sys_clk);
        #2 sys_rst_n = 1'b1;
        while (!((&done_mask()) && frames_seen == PHY_INIT_LEN) && cyc < TIMEOUT_CYCLES) begin
            @(posedge sys_clk);
            cyc = cyc + 1;
        end
        if (cyc >= TIMEOUT_CYCLES) begin
            report_failure($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end else begin
            repeat (SETTLE_CYCLES) begin  // watch for stray frames or writes
                @(posedge sys_clk);
                cyc = cyc + 1;
            end
            @(negedge sys_clk);
            if (o_led != '1) report_mismatch("o_led", {NUM_PORTS{1'b1}}, o_led);
            @(posedge sys_clk);  // last negedge monitor pass is complete here
        end
        $display("pcs_writes=%0d mdio_frames=%0d errors=%0d", pcs_writes, frames_seen, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
tsn_mgmt_pkg.sv
phy_reset_ctrl.sv
mdio_init_master.sv
pcs_config_seq.sv
pcs_reg_arbiter.sv
tsn_mgmt_top.sv
tb_tsn_mgmt_assertions.sv
tb_tsn_mgmt.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the tsn_mgmt testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_tsn_mgmt -f sources.f -o Vtb_tsn_mgmt

./obj_dir/Vtb_tsn_mgmt > sim.log 2>&1 || true
cat sim.log

if grep -q "^No errors$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
